/* rsp_prep.f */
+incdir+source
source/rsp_prep_pkg.sv
source/rsp_prep_ctrl.sv
source/rsp_prep_coef_mem.sv
source/rsp_prep_offset_sub.sv
source/rsp_prep_cmul.sv
source/rsp_prep_top.sv
bench/rsp_prep_tb.sv

/* bench/rsp_prep_tb.sv */
`timescale 1ns/1ps
`include "rsp_prep_macros.svh"

module rsp_prep_tb;
  import rsp_prep_pkg::*;

  localparam int N = `RSP_CHIRP_LEN;
  localparam int IDLE_LIMIT = 300;

  logic       clk;
  logic       rst_n;
  logic       i_coef_we;
  coef_addr_t i_coef_addr;
  coef_t      i_coef_data;
  cpx_t       i_offset;
  logic       i_bypass;
  logic       i_chirp_start;
  logic       i_valid;
  cpx_t       i_data;
  logic       o_valid;
  cpx_t       o_data;
  logic       o_busy;
  logic       o_chirp_done;

  // bench state
  logic [31:0] rng;
  int          cyc;
  int          errors;
  int          checks;
  coef_t       coef_mdl [N];
  cpx_t        smp_buf [N];
  cpx_t        exp_q [$];
  cpx_t        exp_y;
  int          out_seen;
  int          done_cnt;
  int          done_cyc;
  int          first_in_cyc;
  int          first_out_cyc;
  int          last_out_cyc;

  rsp_prep_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_coef_we     (i_coef_we),
    .i_coef_addr   (i_coef_addr),
    .i_coef_data   (i_coef_data),
    .i_offset      (i_offset),
    .i_bypass      (i_bypass),
    .i_chirp_start (i_chirp_start),
    .i_valid       (i_valid),
    .i_data        (i_data),
    .o_valid       (o_valid),
    .o_data        (o_data),
    .o_busy        (o_busy),
    .o_chirp_done  (o_chirp_done)
  );

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  // cycle number, settled by the time inputs change
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // symmetric clamp, -32768 is never a result
  function automatic part_t sat_part(input longint v);
    if (v > 32767) begin
      return 16'sd32767;
    end else if (v < -32767) begin
      return -16'sd32767;
    end
    return part_t'(v);
  endfunction

  // y = sat((x - u) * w >>> 23), or x itself in bypass
  function automatic cpx_t expected_word(input cpx_t x, input cpx_t u,
                                         input coef_t w, input logic byp);
    longint a;
    longint b;
    longint re;
    longint im;
    cpx_t   y;
    if (byp) begin
      return x;
    end
    a = sat_part(longint'(x.re) - longint'(u.re));
    b = sat_part(longint'(x.im) - longint'(u.im));
    re = a * longint'(w.re) - b * longint'(w.im);
    im = a * longint'(w.im) + b * longint'(w.re);
    y.re = sat_part(re >>> `RSP_FRAC);
    y.im = sat_part(im >>> `RSP_FRAC);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err0);
    $display("%-26s %0d errors", name, errors - err0);
  endtask

  // inputs change 10 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (o_busy === 1'b1 && n < limit) begin
      next_cycle();
      n++;
    end
    if (o_busy !== 1'b0) begin
      report_error("o_busy never fell, the chirp did not complete");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (o_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_error("o_valid high with no sample outstanding");
        end else begin
          exp_y = exp_q.pop_front();
          check_value("o_data", o_data, exp_y);
        end
        if (out_seen == 0) begin
          first_out_cyc = cyc;
        end
        out_seen++;
        last_out_cyc = cyc;
      end
      if (o_chirp_done === 1'b1) begin
        done_cnt++;
        done_cyc = cyc;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic load_coefs();
    i_coef_we = 1'b1;
    for (int k = 0; k < N; k++) begin
      i_coef_addr = coef_addr_t'(k);
      i_coef_data = coef_mdl[k];
      next_cycle();
    end
    i_coef_we = 1'b0;
  endtask

  // one chirp from smp_buf, optional gaps and stray start pulses
  task automatic run_chirp(input logic byp, input int gap_pct, input logic stray);
    int k;
    int lat;
    lat = byp ? 4 : 7;
    out_seen = 0;
    done_cnt = 0;
    done_cyc = -1;
    first_in_cyc = -1;
    first_out_cyc = -1;
    last_out_cyc = -2;
    i_bypass = byp;
    i_chirp_start = 1'b1;
    next_cycle();
    i_chirp_start = 1'b0;
    k = 0;
    while (k < N) begin
      if (gap_pct > 0 && (next_rand() % 100) < gap_pct) begin
        // junk on the bus while not valid
        i_valid = 1'b0;
        i_data = next_rand();
      end else begin
        i_valid = 1'b1;
        i_data = smp_buf[k];
        exp_q.push_back(expected_word(smp_buf[k], i_offset, coef_mdl[k], byp));
        if (k == 0) begin
          first_in_cyc = cyc;
        end
        // start while running, other mode requested
        if (stray && k == 10) begin
          i_chirp_start = 1'b1;
          i_bypass = ~byp;
        end
        k++;
      end
      next_cycle();
      i_chirp_start = 1'b0;
    end
    i_valid = 1'b0;
    // start again while draining
    if (stray) begin
      i_chirp_start = 1'b1;
      i_bypass = ~byp;
      next_cycle();
      i_chirp_start = 1'b0;
    end
    wait_idle(IDLE_LIMIT);
    check_value("o_valid count", out_seen, N);
    check_value("o_chirp_done count", done_cnt, 1);
    check_value("o_chirp_done cycle", done_cyc, last_out_cyc);
    check_value("first o_valid latency", first_out_cyc - first_in_cyc, lat);
    check_value("outputs still pending", exp_q.size(), 0);
    exp_q.delete();
  endtask

  task automatic fill_random(input logic coefs);
    logic [31:0] r1;
    logic [31:0] r2;
    for (int k = 0; k < N; k++) begin
      smp_buf[k] = next_rand();
      if (coefs) begin
        r1 = next_rand();
        r2 = next_rand();
        coef_mdl[k].re = r1[23:0];
        coef_mdl[k].im = r2[23:0];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_and_idle();
    int err0;
    err0 = errors;
    check_value("o_valid", o_valid, 0);
    check_value("o_busy", o_busy, 0);
    check_value("o_chirp_done", o_chirp_done, 0);
    // offered while idle, must be dropped
    for (int k = 0; k < 4; k++) begin
      i_valid = 1'b1;
      i_data = next_rand();
      next_cycle();
    end
    i_valid = 1'b0;
    // observation window longer than the deepest path
    repeat (12) next_cycle();
    check_value("o_busy", o_busy, 0);
    finish_test("reset and idle drop", err0);
  endtask

  task automatic unit_coef_chirp();
    int err0;
    err0 = errors;
    fill_random(1'b0);
    for (int k = 0; k < N; k++) begin
      coef_mdl[k].re = 24'sh7fffff;
      coef_mdl[k].im = '0;
    end
    load_coefs();
    i_offset = '0;
    run_chirp(1'b0, 0, 1'b0);
    finish_test("unit coefficients", err0);
  endtask

  task automatic random_chirp();
    int err0;
    err0 = errors;
    fill_random(1'b1);
    load_coefs();
    i_offset = next_rand();
    run_chirp(1'b0, 30, 1'b0);
    finish_test("random with gaps", err0);
  endtask

  // extremes push both the subtract and the product over the limits
  task automatic saturation_chirp();
    int err0;
    err0 = errors;
    for (int k = 0; k < N; k++) begin
      case (k % 4)
        0: smp_buf[k] = {16'sh7fff, 16'sh8000};
        1: smp_buf[k] = {16'sh8000, 16'sh7fff};
        2: smp_buf[k] = {16'sh7fff, 16'sh7fff};
        default: smp_buf[k] = {16'sh8000, 16'sh8000};
      endcase
      coef_mdl[k].re = 24'sh7fffff;
      coef_mdl[k].im = ((k / 4) % 2 == 0) ? 24'sh7fffff : 24'sh800000;
    end
    load_coefs();
    i_offset.re = 16'sd20000;
    i_offset.im = -16'sd20000;
    run_chirp(1'b0, 0, 1'b0);
    finish_test("saturation", err0);
  endtask

  task automatic bypass_chirp();
    int err0;
    err0 = errors;
    fill_random(1'b1);
    load_coefs();
    i_offset = next_rand();
    run_chirp(1'b1, 25, 1'b0);
    finish_test("bypass", err0);
  endtask

  task automatic start_while_busy();
    int err0;
    err0 = errors;
    fill_random(1'b0);
    i_offset = next_rand();
    run_chirp(1'b0, 10, 1'b1);
    // next chirp in the other mode
    fill_random(1'b0);
    run_chirp(1'b1, 0, 1'b0);
    finish_test("start while busy", err0);
  endtask

  initial begin
    rng = 32'ha86;
    cyc = 0;
    errors = 0;
    checks = 0;
    out_seen = 0;
    done_cnt = 0;
    rst_n = 1'b0;
    i_coef_we = 1'b0;
    i_coef_addr = '0;
    i_coef_data = '0;
    i_offset = '0;
    i_bypass = 1'b0;
    i_chirp_start = 1'b0;
    i_valid = 1'b0;
    i_data = '0;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
    next_cycle();

    reset_and_idle();
    unit_coef_chirp();
    random_chirp();
    saturation_chirp();
    bypass_chirp();
    start_while_busy();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* source/rsp_prep_top.sv */
`timescale 1ns/1ps

module rsp_prep_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_coef_we,
  input  rsp_prep_pkg::coef_addr_t i_coef_addr,
  input  rsp_prep_pkg::coef_t      i_coef_data,
  input  rsp_prep_pkg::cpx_t       i_offset,
  input  logic                     i_bypass,
  input  logic                     i_chirp_start,
  input  logic                     i_valid,
  input  rsp_prep_pkg::cpx_t       i_data,
  output logic                     o_valid,
  output rsp_prep_pkg::cpx_t       o_data,
  output logic                     o_busy,
  output logic                     o_chirp_done
);
  import rsp_prep_pkg::*;

  logic       in_valid;
  logic       mode;
  coef_addr_t index;
  logic       sub_valid;
  cpx_t       sub_y;
  coef_t      coef_rd;
  beat_t      beat;

  // sequencing and sample gating
  rsp_prep_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_chirp_start (i_chirp_start),
    .i_bypass      (i_bypass),
    .i_valid       (i_valid),
    .i_out_valid   (o_valid),
    .o_in_valid    (in_valid),
    .o_mode        (mode),
    .o_busy        (o_busy),
    .o_chirp_done  (o_chirp_done),
    .o_index       (index)
  );

  // coef read lines up with subtractor output
  rsp_prep_coef_mem u_coef_mem (
    .clk     (clk),
    .i_we    (i_coef_we),
    .i_waddr (i_coef_addr),
    .i_wdata (i_coef_data),
    .i_raddr (index),
    .o_rdata (coef_rd)
  );

  rsp_prep_offset_sub u_offset_sub (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (in_valid),
    .i_mode  (mode),
    .i_x     (i_data),
    .i_u     (i_offset),
    .o_valid (sub_valid),
    .o_y     (sub_y)
  );

  // sample plus coefficient into one beat
  assign beat = '{valid: sub_valid, smp: sub_y, coef: coef_rd};

  rsp_prep_cmul u_cmul (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_mode  (mode),
    .i_beat  (beat),
    .o_valid (o_valid),
    .o_y     (o_data)
  );

endmodule

/* source/rsp_prep_cmul.sv */
`timescale 1ns/1ps
`include "rsp_prep_macros.svh"

module rsp_prep_cmul (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_mode,
  input  rsp_prep_pkg::beat_t i_beat,
  output logic                o_valid,
  output rsp_prep_pkg::cpx_t  o_y
);
  import rsp_prep_pkg::*;

  // a*d and b*c width
  localparam int PROD_W = `RSP_SAMPLE_W + `RSP_COEF_W;
  // (a+b)*(c-d) width
  localparam int SUM_W = PROD_W + 2;
  // real part accumulator
  localparam int ACC_W = PROD_W + 3;
  localparam logic signed [ACC_W-1:0] LIM = 2**(`RSP_SAMPLE_W-1) - 1;

  // drop Q1.23 fraction, clamp to +-32767 (neg limit 0x8001)
  function automatic part_t scale_sat(input logic signed [ACC_W-1:0] v);
    logic signed [ACC_W-1:0] sh;
    part_t                   r;
    sh = v >>> `RSP_FRAC;
    if (sh > LIM) begin
      r = part_t'(LIM);
    end else if (sh < -LIM) begin
      r = part_t'(-LIM);
    end else begin
      r = part_t'(sh);
    end
    return r;
  endfunction

  // x = a + jb, w = c + jd
  part_t  a;
  part_t  b;
  wpart_t c;
  wpart_t d;

  // stage 1, operands and pre-adds
  part_t                           s1_a;
  part_t                           s1_b;
  wpart_t                          s1_c;
  wpart_t                          s1_d;
  logic signed [`RSP_SAMPLE_W:0]   s1_sum;
  logic signed [`RSP_COEF_W:0]     s1_dif;
  // stages 2 and 3, the three products
  logic signed [PROD_W-1:0]        s2_ad;
  logic signed [PROD_W-1:0]        s2_bc;
  logic signed [SUM_W-1:0]         s2_sd;
  logic signed [PROD_W-1:0]        s3_ad;
  logic signed [PROD_W-1:0]        s3_bc;
  logic signed [SUM_W-1:0]         s3_sd;
  // stage 4, ad-bc and ad+bc
  logic signed [PROD_W:0]          s4_dif;
  logic signed [PROD_W:0]          s4_im;
  logic signed [SUM_W-1:0]         s4_sd;
  // stage 5, full-precision result
  logic signed [ACC_W-1:0]         s5_re;
  logic signed [PROD_W:0]          s5_im;
  // stage 6, scaled output
  cpx_t                            cm_y;
  logic [`RSP_CMUL_LAT-1:0]        cm_vld;

  // bypass delay line
  logic [`RSP_BYP_LAT-1:0]         by_vld;
  cpx_t                            by_dat [`RSP_BYP_LAT];

  assign a = i_beat.smp.re;
  assign b = i_beat.smp.im;
  assign c = i_beat.coef.re;
  assign d = i_beat.coef.im;

  //////////////////////////////////////////////////////////////////////
  // complex path
  // re = (a+b)(c-d) + ad - bc, im = ad + bc
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // pre-adds one stage ahead of the multipliers
    s1_a   <= a;
    s1_b   <= b;
    s1_c   <= c;
    s1_d   <= d;
    s1_sum <= a + b;
    s1_dif <= c - d;
    // three real multiplies
    s2_ad <= s1_a * s1_d;
    s2_bc <= s1_b * s1_c;
    s2_sd <= s1_sum * s1_dif;
    // product register, eases dsp timing
    s3_ad <= s2_ad;
    s3_bc <= s2_bc;
    s3_sd <= s2_sd;
    // cross terms
    s4_dif <= s3_ad - s3_bc;
    s4_im  <= s3_ad + s3_bc;
    s4_sd  <= s3_sd;
    // real sum, imag just rides along
    s5_re <= s4_sd + s4_dif;
    s5_im <= s4_im;
    // scale and saturate
    cm_y.re <= scale_sat(s5_re);
    cm_y.im <= scale_sat(s5_im);
  end

  // valid chain matches the 6 data stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cm_vld <= '0;
    end else begin
      cm_vld <= {cm_vld[`RSP_CMUL_LAT-2:0], i_beat.valid & ~i_mode};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bypass path, word passes untouched
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      by_vld <= '0;
    end else begin
      by_vld <= {by_vld[`RSP_BYP_LAT-2:0], i_beat.valid & i_mode};
    end
  end

  always_ff @(posedge clk) begin
    by_dat[0] <= i_beat.smp;
    for (int i = 1; i < `RSP_BYP_LAT; i++) begin
      by_dat[i] <= by_dat[i-1];
    end
  end

  // mode fixed per chirp, paths never overlap
  assign o_valid = i_mode ? by_vld[`RSP_BYP_LAT-1] : cm_vld[`RSP_CMUL_LAT-1];
  assign o_y     = i_mode ? by_dat[`RSP_BYP_LAT-1] : cm_y;

endmodule

/* source/rsp_prep_offset_sub.sv */
`timescale 1ns/1ps
`include "rsp_prep_macros.svh"

module rsp_prep_offset_sub (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_valid,
  input  logic               i_mode,
  input  rsp_prep_pkg::cpx_t i_x,
  input  rsp_prep_pkg::cpx_t i_u,
  output logic               o_valid,
  output rsp_prep_pkg::cpx_t o_y
);
  import rsp_prep_pkg::*;

  // symmetric limit, -32768 never produced
  localparam logic signed [`RSP_SAMPLE_W:0] LIM = 2**(`RSP_SAMPLE_W-1) - 1;

  // x - u with one guard bit, then clamp
  function automatic part_t sat_sub(input part_t x, input part_t u);
    logic signed [`RSP_SAMPLE_W:0] d;
    part_t                         r;
    d = x - u;
    if (d > LIM) begin
      r = part_t'(LIM);
    end else if (d < -LIM) begin
      r = part_t'(-LIM);
    end else begin
      r = part_t'(d);
    end
    return r;
  endfunction

  // valid follows the data by one stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // bypass keeps the two real samples as they are
  always_ff @(posedge clk) begin
    if (i_mode) begin
      o_y <= i_x;
    end else begin
      o_y.re <= sat_sub(i_x.re, i_u.re);
      o_y.im <= sat_sub(i_x.im, i_u.im);
    end
  end

endmodule

/* source/rsp_prep_coef_mem.sv */
`timescale 1ns/1ps
`include "rsp_prep_macros.svh"

module rsp_prep_coef_mem (
  input  logic                     clk,
  input  logic                     i_we,
  input  rsp_prep_pkg::coef_addr_t i_waddr,
  input  rsp_prep_pkg::coef_t      i_wdata,
  input  rsp_prep_pkg::coef_addr_t i_raddr,
  output rsp_prep_pkg::coef_t      o_rdata
);
  import rsp_prep_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // coefficient storage, one word per sample
  //////////////////////////////////////////////////////////////////////

  // maps to block or distributed ram
  coef_t mem [`RSP_CHIRP_LEN];

  // host port, one word per strobe cycle
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // registered read
  // data lands with the subtractor output
  always_ff @(posedge clk) begin
    o_rdata <= mem[i_raddr];
  end

endmodule

/* source/rsp_prep_ctrl.sv */
`timescale 1ns/1ps
`include "rsp_prep_macros.svh"

module rsp_prep_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_chirp_start,
  input  logic                     i_bypass,
  input  logic                     i_valid,
  input  logic                     i_out_valid,
  output logic                     o_in_valid,
  output logic                     o_mode,
  output logic                     o_busy,
  output logic                     o_chirp_done,
  output rsp_prep_pkg::coef_addr_t o_index
);
  import rsp_prep_pkg::*;

  // index of the last sample in a chirp
  localparam coef_addr_t LAST_IDX = coef_addr_t'(`RSP_CHIRP_LEN - 1);

  ctrl_state_t state;
  coef_addr_t  in_cnt;
  coef_addr_t  out_cnt;
  logic        start_ok;
  logic        last_in;

  //////////////////////////////////////////////////////////////////////
  // strobes
  //////////////////////////////////////////////////////////////////////

  // new chirp only accepted from idle
  assign start_ok = i_chirp_start && (state == ST_IDLE);
  // samples pass only while running
  assign o_in_valid = i_valid && (state == ST_RUN);
  assign last_in = o_in_valid && (in_cnt == LAST_IDX);
  // done comes with the final output beat
  assign o_chirp_done = i_out_valid && (state != ST_IDLE) && (out_cnt == LAST_IDX);
  assign o_busy = (state != ST_IDLE);
  // accepted sample number doubles as coef address
  assign o_index = in_cnt;

  //////////////////////////////////////////////////////////////////////
  // chirp FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_ok) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          // all inputs taken, wait for the tail
          if (last_in) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (o_chirp_done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // mode and counters, both restart per chirp
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_mode  <= 1'b0;
      in_cnt  <= '0;
      out_cnt <= '0;
    end else if (start_ok) begin
      o_mode  <= i_bypass;
      in_cnt  <= '0;
      out_cnt <= '0;
    end else begin
      if (o_in_valid) begin
        in_cnt <= in_cnt + 1'b1;
      end
      if (i_out_valid && (state != ST_IDLE)) begin
        out_cnt <= out_cnt + 1'b1;
      end
    end
  end

endmodule

/* source/rsp_prep_pkg.sv */
`include "rsp_prep_macros.svh"

package rsp_prep_pkg;

  // one signed sample part
  typedef logic signed [`RSP_SAMPLE_W-1:0] part_t;

  // complex sample word, imag in upper half
  typedef struct packed {
    part_t im;
    part_t re;
  } cpx_t;

  // one signed coefficient part
  typedef logic signed [`RSP_COEF_W-1:0] wpart_t;

  // complex coefficient, 48 bits
  typedef struct packed {
    wpart_t im;
    wpart_t re;
  } coef_t;

  // sample index and coefficient address
  typedef logic [`RSP_COEF_AW-1:0] coef_addr_t;

  // one multiplier input item
  typedef struct packed {
    logic  valid;
    cpx_t  smp;
    coef_t coef;
  } beat_t;

  // chirp sequencing
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN
  } ctrl_state_t;

endpackage

/* source/rsp_prep_macros.svh */
`ifndef RSP_PREP_MACROS_SVH
`define RSP_PREP_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////////////////////////

// one sample part, re or im
`define RSP_SAMPLE_W 16
// one coefficient part, Q1.23
`define RSP_COEF_W 24
`define RSP_FRAC 23

//////////////////////////////////////////////////////////////////////
// chirp geometry and pipeline depths
//////////////////////////////////////////////////////////////////////

`define RSP_CHIRP_LEN 64
// log2 of chirp length
`define RSP_COEF_AW 6
// multiplier depth, complex path
`define RSP_CMUL_LAT 6
// multiplier depth, bypass path
`define RSP_BYP_LAT 3

`endif
